/* conv_cfg.svh */
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// datapath widths
`define CONV_PIX_W      8     // pixel, unsigned
`define CONV_COEFF_W    18    // coefficient, signed fixed point
`define CONV_SUM_W      48    // cascade accumulator

// window geometry
`define CONV_K          5     // kernel side
`define CONV_TAPS       25    // kernel side squared

// coefficient format is s.(int).(17-int), also sets the output slice
`define CONV_INT_BITS   1

// switch codes for the kernel select
`define CONV_KSEL_W     8
`define CONV_KER_CENTRE 8'd0  // single tap 12
`define CONV_KER_BINOM  8'd1  // 3x3 binomial around tap 12
`define CONV_KER_FIRST  8'd2  // single tap 0
`define CONV_KER_LAST   8'd16 // single tap 24

`endif

/* conv_pkg.sv */
`include "conv_cfg.svh"

package conv_pkg;

  // one pixel as it enters on a row
  typedef logic [`CONV_PIX_W-1:0] pixel_t;

  // s.int.frac coefficient, 1.0 sits at bit 17 - int bits
  typedef logic signed [`CONV_COEFF_W-1:0] coeff_t;

  // pixel is zero-extended by one bit before the multiply, so this is wide enough
  typedef logic signed [`CONV_PIX_W+`CONV_COEFF_W-1:0] prod_t;

  typedef logic signed [`CONV_SUM_W-1:0] sum_t; // running sum down the cascade

  typedef logic [`CONV_KSEL_W-1:0] ksel_t; // switch code

  // five rows of one column, row0 in the top byte
  typedef struct packed {
    pixel_t row0;
    pixel_t row1;
    pixel_t row2;
    pixel_t row3;
    pixel_t row4;
  } pixel_rows_t;

  // full kernel, entry 0 is the top left tap
  typedef coeff_t [0:`CONV_TAPS-1] coeff_set_t;

endpackage

/* row_aligner.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module row_aligner import conv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  pixel_rows_t rows,     // raw rows, one column per clock
  output pixel_rows_t aligned   // row r delayed by 5*r cycles
);

  pixel_t [0:`CONV_K-1] row_in;  // struct viewed as array, index = row
  pixel_t [0:`CONV_K-1] row_out;

  assign row_in  = rows;
  assign aligned = row_out;

  // row 0 feeds the first taps of the cascade, so it needs no delay
  assign row_out[0] = row_in[0];

  // later rows sit further down the cascade, each row 5 taps deeper
  for (genvar r = 1; r < `CONV_K; r++) begin : g_dly
    localparam int DEPTH = `CONV_K * r; // 5, 10, 15, 20

    pixel_t [DEPTH-1:0] shr; // new pixel enters at the top

    always_ff @(posedge clk) begin
      if (rst) begin
        shr <= '0;
      end else begin
        shr <= {row_in[r], shr[DEPTH-1:1]}; // shift towards index 0
      end
    end

    assign row_out[r] = shr[0]; // oldest entry
  end

endmodule

/* coeff_bank.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module coeff_bank import conv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  ksel_t      sw,      // kernel select code
  output coeff_set_t coeffs   // registered kernel, fed to every tap
);

  localparam int FRAC_BITS = `CONV_COEFF_W - 1 - `CONV_INT_BITS; // 17 - int bits
  localparam int CENTRE    = (`CONV_TAPS - 1) / 2;              // tap 12
  localparam int LAST      = `CONV_TAPS - 1;                    // tap 24

  localparam coeff_t ONE = coeff_t'(1 << FRAC_BITS); // 1.0 in coefficient format

  // builds the table for one code, all unlisted taps stay zero
  function automatic coeff_set_t build_kernel(ksel_t code);
    coeff_set_t k;
    int         unit;
    int         w;
    k    = '0;
    unit = int'(ONE) / 16; // binomial weights are in sixteenths
    case (code)
      `CONV_KER_CENTRE: k[CENTRE] = ONE;
      `CONV_KER_BINOM: begin
        // 1 2 1 / 2 4 2 / 1 2 1 as product of two 1 2 1 rows
        for (int dr = -1; dr <= 1; dr++) begin
          for (int dc = -1; dc <= 1; dc++) begin
            w = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
            k[CENTRE + dr * `CONV_K + dc] = coeff_t'(unit * w);
          end
        end
      end
      `CONV_KER_FIRST: k[0]    = ONE;
      `CONV_KER_LAST:  k[LAST] = ONE;
      default:         k       = '0;
    endcase
    return k;
  endfunction

  localparam coeff_set_t KER_CENTRE = build_kernel(`CONV_KER_CENTRE);
  localparam coeff_set_t KER_BINOM  = build_kernel(`CONV_KER_BINOM);
  localparam coeff_set_t KER_FIRST  = build_kernel(`CONV_KER_FIRST);
  localparam coeff_set_t KER_LAST   = build_kernel(`CONV_KER_LAST);

  // new kernel is taken at the edge that samples sw
  always_ff @(posedge clk) begin
    if (rst) begin
      coeffs <= KER_CENTRE; // defined output straight after reset
    end else begin
      case (sw)
        `CONV_KER_CENTRE: coeffs <= KER_CENTRE;
        `CONV_KER_BINOM:  coeffs <= KER_BINOM;
        `CONV_KER_FIRST:  coeffs <= KER_FIRST;
        `CONV_KER_LAST:   coeffs <= KER_LAST;
        default: begin
          // unknown code, last kernel stays loaded
        end
      endcase
    end
  end

endmodule

/* mac_tap.sv */
`timescale 1ns/100ps

module mac_tap import conv_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  pixel_t pix,      // aligned pixel for this tap's row
  input  coeff_t coeff,    // this tap's weight
  input  sum_t   sum_in,   // previous tap's sum register, zero at tap 0
  output sum_t   sum_out
);

  pixel_t pix_q;    // stage 1
  coeff_t coeff_q;  // stage 1
  prod_t  prod_q;   // stage 2
  sum_t   sum_q;    // stage 3

  // three register stages per tap
  // only the sum stage sits in the cascade path, so neighbouring taps are one cycle apart
  always_ff @(posedge clk) begin
    if (rst) begin
      pix_q   <= '0;
      coeff_q <= '0;
      prod_q  <= '0;
      sum_q   <= '0;
    end else begin
      pix_q   <= pix;
      coeff_q <= coeff;
      // pixel is unsigned, extend with a zero sign bit before the signed multiply
      prod_q  <= prod_t'($signed({1'b0, pix_q})) * prod_t'(coeff_q);
      sum_q   <= sum_in + sum_t'(prod_q); // product sign-extended to 48 bits
    end
  end

  assign sum_out = sum_q;

endmodule

/* mac_chain.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module mac_chain import conv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  pixel_rows_t aligned,  // rows already on one time base
  input  coeff_set_t  coeffs,   // current kernel
  output sum_t        sum       // last tap's sum register
);

  pixel_t [0:`CONV_K-1] row_px;       // index = row
  sum_t                 cas [0:`CONV_TAPS]; // cas[i] feeds tap i

  assign row_px = aligned;
  assign cas[0] = '0; // head of cascade

  // tap i covers row i/5, column i%5. the column offset comes from the
  // one-cycle-per-tap skew of the sum chain itself
  for (genvar i = 0; i < `CONV_TAPS; i++) begin : g_tap
    mac_tap i_tap (
      .clk     (clk),
      .rst     (rst),
      .pix     (row_px[i / `CONV_K]), // all taps of a row share the pixel
      .coeff   (coeffs[i]),
      .sum_in  (cas[i]),
      .sum_out (cas[i+1])
    );
  end

  assign sum = cas[`CONV_TAPS];

endmodule

/* conv5x5_top.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module conv5x5_top import conv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  ksel_t       sw,      // kernel select, held as a level
  input  pixel_rows_t rows,    // five input rows, new column every clock
  output pixel_t      p_out    // filtered pixel
);

  // lsb of the integer part of the sum, 1.0 times pixel lands at [lsb+7:lsb]
  localparam int OUT_LSB = `CONV_COEFF_W - 1 - `CONV_INT_BITS;
  localparam int OUT_MSB = OUT_LSB + `CONV_PIX_W - 1;

  pixel_rows_t aligned;
  coeff_set_t  coeffs;
  sum_t        sum;

  row_aligner i_aligner (
    .clk     (clk),
    .rst     (rst),
    .rows    (rows),
    .aligned (aligned)
  );

  coeff_bank i_bank (
    .clk    (clk),
    .rst    (rst),
    .sw     (sw),
    .coeffs (coeffs)
  );

  mac_chain i_chain (
    .clk     (clk),
    .rst     (rst),
    .aligned (aligned),
    .coeffs  (coeffs),
    .sum     (sum)
  );

  // plain truncation, no rounding and no clamp on overflow
  assign p_out = sum[OUT_MSB:OUT_LSB];

endmodule

/* conv5x5_props.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module conv5x5_props import conv_pkg::*; (
  input logic        clk,
  input logic        rst,
  input ksel_t       sw,
  input pixel_rows_t rows,
  input pixel_rows_t aligned,  // aligner output inside the top
  input coeff_set_t  coeffs,   // coefficient bank register
  input pixel_t      p_out
);

  logic listed; // sw names one of the four kernels

  assign listed = (sw == `CONV_KER_CENTRE) || (sw == `CONV_KER_BINOM) ||
                  (sw == `CONV_KER_FIRST) || (sw == `CONV_KER_LAST);

  // whole pipeline is cleared, so the last sum stays zero while it refills
  a_reset_zero: assert property (@(posedge clk)
    ($past(rst) || $past(rst, 2) || $past(rst, 3)) |-> (p_out == '0))
    else $error("p_out not zero in the first cycles after reset");

  // unknown code keeps the loaded kernel
  a_kernel_hold: assert property (@(posedge clk) disable iff (rst)
    !listed |=> $stable(coeffs))
    else $error("coefficient bank changed on an unlisted switch code");

  // row 1 leaves the aligner 5 cycles after it enters once 5 clean cycles have passed
  a_row1_delay: assert property (@(posedge clk) disable iff (rst)
    !($past(rst) || $past(rst, 2) || $past(rst, 3) || $past(rst, 4) || $past(rst, 5))
    |-> (aligned.row1 == $past(rows.row1, 5)))
    else $error("row 1 not delayed by 5 cycles in the aligner");

endmodule

bind conv5x5_top conv5x5_props i_props (
  .clk     (clk),
  .rst     (rst),
  .sw      (sw),
  .rows    (rows),
  .aligned (aligned),
  .coeffs  (coeffs),
  .p_out   (p_out)
);

/* tb_conv5x5.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module tb_conv5x5 import conv_pkg::*; ();

  localparam int RST_CYC  = 5;
  localparam int LATENCY  = 26;      // row r, column c seen at edge n-26+c
  localparam int SETTLE   = 28;      // cycles after a kernel change before checks
  localparam int MAX_CYC  = 1024;    // history depth
  localparam int FRAC     = `CONV_COEFF_W - 1 - `CONV_INT_BITS;
  localparam int NSTEPS   = 8;

  localparam logic [1:0] SRC_CONST = 2'd0;
  localparam logic [1:0] SRC_RAMP  = 2'd1;
  localparam logic [1:0] SRC_RAND  = 2'd2;

  // one row of the stimulus table
  typedef struct packed {
    ksel_t      code;     // value driven on sw
    logic [1:0] src;      // pixel source
    pixel_t     value;    // constant value or ramp base
    ksel_t      exp_ker;  // kernel expected in the bank
    logic [15:0] ncols;   // columns driven
  } step_t;

  localparam step_t STEPS [0:NSTEPS-1] = '{
    '{`CONV_KER_CENTRE, SRC_RAMP,  8'd0,   `CONV_KER_CENTRE, 16'd60}, // zeros then row 2
    '{`CONV_KER_FIRST,  SRC_RAND,  8'd0,   `CONV_KER_FIRST,  16'd60},
    '{8'd3,             SRC_RAND,  8'd0,   `CONV_KER_FIRST,  16'd40}, // unlisted, hold
    '{`CONV_KER_LAST,   SRC_RAMP,  8'd17,  `CONV_KER_LAST,   16'd60},
    '{8'd128,           SRC_CONST, 8'hc3,  `CONV_KER_LAST,   16'd40}, // unlisted, hold
    '{`CONV_KER_BINOM,  SRC_RAND,  8'd0,   `CONV_KER_BINOM,  16'd80},
    '{`CONV_KER_BINOM,  SRC_CONST, 8'hff,  `CONV_KER_BINOM,  16'd40}, // full scale
    '{`CONV_KER_CENTRE, SRC_RAND,  8'd0,   `CONV_KER_CENTRE, 16'd60}
  };

  // binomial weights in sixteenths, tap 0 top left
  localparam int BINOM_W [0:`CONV_TAPS-1] = '{
    0, 0, 0, 0, 0,
    0, 1, 2, 1, 0,
    0, 2, 4, 2, 0,
    0, 1, 2, 1, 0,
    0, 0, 0, 0, 0
  };

  logic        clk;
  logic        rst;
  ksel_t       sw;
  pixel_rows_t rows;
  pixel_t      p_out;

  int          cyc;                   // rising edges seen so far
  logic [31:0] lfsr;
  pixel_rows_t row_hist [0:MAX_CYC-1]; // rows sampled at edge k
  ksel_t       ker_hist [0:MAX_CYC-1]; // kernel in the bank after edge k

  conv5x5_top i_dut (
    .clk   (clk),
    .rst   (rst),
    .sw    (sw),
    .rows  (rows),
    .p_out (p_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
  endfunction

  function automatic pixel_t random_pixel();
    pixel_t p;
    p = '0;
    for (int b = 0; b < `CONV_PIX_W; b++) begin
      lfsr = lfsr_step(lfsr); // one step per bit
      p = {p[`CONV_PIX_W-2:0], lfsr[0]};
    end
    return p;
  endfunction

  function automatic pixel_rows_t make_column(step_t s, int col);
    pixel_t px [0:`CONV_K-1];
    for (int r = 0; r < `CONV_K; r++) begin
      case (s.src)
        SRC_RAMP: px[r] = pixel_t'(int'(s.value) + col + 37 * r); // per row offset
        SRC_RAND: px[r] = random_pixel();
        default:  px[r] = s.value;
      endcase
    end
    return '{row0: px[0], row1: px[1], row2: px[2], row3: px[3], row4: px[4]};
  endfunction

  // weight of one tap in sixteenths of 1.0
  function automatic int kernel_weight(ksel_t ker, int t);
    case (ker)
      `CONV_KER_CENTRE: return (t == 12) ? 16 : 0;
      `CONV_KER_BINOM:  return BINOM_W[t];
      `CONV_KER_FIRST:  return (t == 0) ? 16 : 0;
      `CONV_KER_LAST:   return (t == `CONV_TAPS - 1) ? 16 : 0;
      default:          return 0;
    endcase
  endfunction

  function automatic int row_pixel(int k, int r);
    pixel_rows_t c;
    if (k < 1) return 0; // before the first edge
    c = row_hist[k];
    case (r)
      0:       return int'(c.row0);
      1:       return int'(c.row1);
      2:       return int'(c.row2);
      3:       return int'(c.row3);
      default: return int'(c.row4);
    endcase
  endfunction

  // weighted window at edge n, then the byte above the binary point
  function automatic pixel_t expected_out(int n);
    longint acc;
    longint full;
    acc = 0;
    for (int r = 0; r < `CONV_K; r++) begin
      for (int c = 0; c < `CONV_K; c++) begin
        acc += longint'(kernel_weight(ker_hist[n], r * `CONV_K + c) *
                        row_pixel(n - LATENCY + c, r));
      end
    end
    full = acc * ((longint'(1) << FRAC) / 16); // sixteenths into coefficient scale
    return pixel_t'(full >> FRAC);
  endfunction

  function automatic int run_budget();
    int total;
    total = RST_CYC + 100;
    for (int i = 0; i < NSTEPS; i++) total += int'(STEPS[i].ncols);
    return total;
  endfunction

  task automatic check_pixel(string name, pixel_t got, pixel_t want);
    if (got !== want) begin
      $display("** Error: %s = 0x%02h, expected 0x%02h at cycle %0d", name, got, want, cyc);
      $display("TEST FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  initial begin
    repeat (run_budget()) @(posedge clk);
    $display("watchdog: run did not finish within %0d clock cycles", run_budget());
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    step_t       st;
    pixel_rows_t px;
    int          n_checked;
    int          last_change;
    rst         = 1'b1;
    sw          = `CONV_KER_CENTRE;
    rows        = '0;
    cyc         = 0;
    lfsr        = 32'hcfec;
    n_checked   = 0;
    last_change = -1000; // reset leaves kernel 0 loaded, no settle wait
    repeat (RST_CYC) begin
      @(posedge clk);
      cyc++;
      row_hist[cyc] = '0;
      ker_hist[cyc] = `CONV_KER_CENTRE;
    end
    #2;
    rst = 1'b0;
    for (int i = 0; i < NSTEPS; i++) begin
      st = STEPS[i];
      for (int col = 0; col < int'(st.ncols); col++) begin
        px   = make_column(st, col);
        sw   = st.code;
        rows = px;
        row_hist[cyc+1] = px;          // sampled at the next edge
        ker_hist[cyc+1] = st.exp_ker;
        if (ker_hist[cyc+1] != ker_hist[cyc]) last_change = cyc + 1;
        @(posedge clk);
        cyc++;
        #2;
        if (cyc >= last_change + SETTLE) begin // all taps on one kernel
          check_pixel("p_out", p_out, expected_out(cyc));
          n_checked++;
        end
      end
    end
    if (n_checked > 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("no cycle of the stimulus table was compared with the model");
      $display("TEST FAILED");
      $fatal(1, "nothing checked");
    end
  end

endmodule

/* conv5x5_top.f */
+incdir+.
conv_pkg.sv
row_aligner.sv
coeff_bank.sv
mac_tap.sv
mac_chain.sv
conv5x5_top.sv
conv5x5_props.sv
tb_conv5x5.sv

/* Makefile */
# Verilator build and run for the 5x5 convolution filter

VERILATOR ?= verilator
TOP       ?= tb_conv5x5
FILELIST  ?= conv5x5_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator output is kept in a shell variable and searched for the pass line
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
